// File: rtl/preview_pkg.sv
`default_nettype none

package preview_pkg;

    ////////////////////
    // widths and types

    typedef logic [7:0]  pixel_t;
    typedef logic [15:0] dim_t;
    typedef logic [15:0] cmd_addr_t;
    typedef logic [31:0] cmd_data_t;

    ////////////////////
    // frame header

    // spells BIVFRAME, sent msb first
    localparam logic [63:0] MAGIC_NUM = 64'h42_49_56_46_52_41_4D_45;
    localparam int HEADER_BYTES = 8;
    localparam int HDR_IDX_W = 3;
    localparam logic [HDR_IDX_W-1:0] HDR_LAST = HDR_IDX_W'(HEADER_BYTES - 1);

    ////////////////////
    // host commands

    localparam int CMD_BYTES = 6;
    localparam int CMD_W = 48;
    localparam int CMD_CNT_W = 3;
    localparam logic [CMD_CNT_W-1:0] CMD_LAST = CMD_CNT_W'(CMD_BYTES - 1);

    localparam cmd_addr_t ADDR_FRAME_WIDTH  = 16'h0010;
    localparam cmd_addr_t ADDR_FRAME_HEIGHT = 16'h0011;

    // frame size out of reset
    localparam dim_t DEFAULT_WIDTH  = 16'd500;
    localparam dim_t DEFAULT_HEIGHT = 16'd480;

    ////////////////////
    // pixel buffer

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = 4;
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;
    localparam logic [FIFO_CNT_W-1:0] FIFO_FULL = FIFO_CNT_W'(FIFO_DEPTH);

    // serializer states
    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        CH0,
        CH1
    } ser_state_t;

endpackage

`default_nettype wire

// File: rtl/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
    input  logic                core_clk,
    input  logic                sys_reset,
    input  preview_pkg::pixel_t push_ch0_i,
    input  preview_pkg::pixel_t push_ch1_i,
    input  logic                push_sof_i,
    input  logic                push_valid_i,
    output logic                push_ready_o,
    output preview_pkg::pixel_t head_ch0_o,
    output preview_pkg::pixel_t head_ch1_o,
    output logic                head_sof_o,
    output logic                head_valid_o,
    input  logic                pop_i
);

    // storage, one entry per pixel pair
    preview_pkg::pixel_t mem_ch0 [preview_pkg::FIFO_DEPTH];
    preview_pkg::pixel_t mem_ch1 [preview_pkg::FIFO_DEPTH];
    logic                mem_sof [preview_pkg::FIFO_DEPTH];

    logic [preview_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
    logic [preview_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
    logic [preview_pkg::FIFO_CNT_W-1:0] count_q;

    logic push_fire;
    logic pop_fire;

    assign push_ready_o = (count_q != preview_pkg::FIFO_FULL);
    assign head_valid_o = (count_q != '0);

    assign push_fire = push_valid_i && push_ready_o;
    assign pop_fire  = pop_i && head_valid_o;

    // first word fall through
    assign head_ch0_o = mem_ch0[rd_ptr_q];
    assign head_ch1_o = mem_ch1[rd_ptr_q];
    assign head_sof_o = mem_sof[rd_ptr_q];

    always_ff @(posedge core_clk) begin
        if (push_fire) begin
            mem_ch0[wr_ptr_q] <= push_ch0_i;
            mem_ch1[wr_ptr_q] <= push_ch1_i;
            mem_sof[wr_ptr_q] <= push_sof_i;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_fire && !pop_fire) begin
                count_q <= count_q + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge core_clk) disable iff (sys_reset)
        pop_i |-> head_valid_o);

    a_count_bound: assert property (@(posedge core_clk) disable iff (sys_reset)
        count_q <= preview_pkg::FIFO_FULL);

endmodule

`default_nettype wire

// File: rtl/frame_position_counter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_position_counter (
    input  logic              core_clk,
    input  logic              sys_reset,
    input  preview_pkg::dim_t frame_width_i,
    input  preview_pkg::dim_t frame_height_i,
    input  logic              frame_start_i,
    input  logic              pixel_done_i,
    output logic              last_pixel_o
);

    // size is frozen for the whole frame
    preview_pkg::dim_t width_q;
    preview_pkg::dim_t height_q;
    preview_pkg::dim_t col_q;
    preview_pkg::dim_t row_q;

    logic last_col;
    logic last_row;

    assign last_col     = (col_q == width_q - 16'd1);
    assign last_row     = (row_q == height_q - 16'd1);
    assign last_pixel_o = last_col && last_row;

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            width_q  <= preview_pkg::DEFAULT_WIDTH;
            height_q <= preview_pkg::DEFAULT_HEIGHT;
            col_q    <= '0;
            row_q    <= '0;
        end else if (frame_start_i) begin
            width_q  <= frame_width_i;
            height_q <= frame_height_i;
            col_q    <= '0;
            row_q    <= '0;
        end else if (pixel_done_i) begin
            // column wraps into the row, row wraps at frame end
            if (last_col) begin
                col_q <= '0;
                row_q <= last_row ? '0 : row_q + 16'd1;
            end else begin
                col_q <= col_q + 16'd1;
            end
        end
    end

    a_col_in_range: assert property (@(posedge core_clk) disable iff (sys_reset)
        col_q < width_q);

endmodule

`default_nettype wire

// File: rtl/frame_serializer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module frame_serializer_fsm (
    input  logic                core_clk,
    input  logic                sys_reset,
    input  preview_pkg::pixel_t head_ch0_i,
    input  preview_pkg::pixel_t head_ch1_i,
    input  logic                head_sof_i,
    input  logic                head_valid_i,
    output logic                pop_o,
    output logic                frame_start_o,
    output logic                pixel_done_o,
    input  logic                last_pixel_i,
    input  logic                host_space_i,
    output preview_pkg::pixel_t byte_o,
    output logic                byte_valid_o
);

    preview_pkg::ser_state_t state_q;
    preview_pkg::ser_state_t state_d;

    logic [preview_pkg::HDR_IDX_W-1:0] hdr_idx_q;
    logic [preview_pkg::HDR_IDX_W-1:0] hdr_idx_d;

    // the sof pixel that opened the frame must not restart it
    logic first_pixel_q;
    logic first_pixel_d;

    logic                emit;
    preview_pkg::pixel_t emit_byte;

    ////////////////////
    // next state

    always_comb begin
        state_d       = state_q;
        hdr_idx_d     = hdr_idx_q;
        first_pixel_d = first_pixel_q;
        emit          = 1'b0;
        emit_byte     = head_ch0_i;
        pop_o         = 1'b0;
        frame_start_o = 1'b0;
        pixel_done_o  = 1'b0;

        case (state_q)
            preview_pkg::IDLE: begin
                if (head_valid_i) begin
                    if (head_sof_i) begin
                        state_d       = preview_pkg::HEADER;
                        hdr_idx_d     = '0;
                        first_pixel_d = 1'b1;
                        frame_start_o = 1'b1;
                    end else begin
                        // outside any frame, drop it
                        pop_o = 1'b1;
                    end
                end
            end
            preview_pkg::HEADER: begin
                if (host_space_i) begin
                    emit      = 1'b1;
                    emit_byte = preview_pkg::MAGIC_NUM[63 - 8 * hdr_idx_q -: 8];
                    hdr_idx_d = hdr_idx_q + 1'b1;
                    if (hdr_idx_q == preview_pkg::HDR_LAST) begin
                        state_d = preview_pkg::CH0;
                    end
                end
            end
            preview_pkg::CH0: begin
                if (head_valid_i) begin
                    if (head_sof_i && !first_pixel_q) begin
                        // new frame mid-way, abandon this one
                        state_d       = preview_pkg::HEADER;
                        hdr_idx_d     = '0;
                        first_pixel_d = 1'b1;
                        frame_start_o = 1'b1;
                    end else if (host_space_i) begin
                        emit      = 1'b1;
                        emit_byte = head_ch0_i;
                        state_d   = preview_pkg::CH1;
                    end
                end
            end
            preview_pkg::CH1: begin
                if (host_space_i && head_valid_i) begin
                    emit          = 1'b1;
                    emit_byte     = head_ch1_i;
                    pop_o         = 1'b1;
                    pixel_done_o  = 1'b1;
                    first_pixel_d = 1'b0;
                    state_d       = last_pixel_i ? preview_pkg::IDLE : preview_pkg::CH0;
                end
            end
            default: begin
                state_d = preview_pkg::IDLE;
            end
        endcase
    end

    ////////////////////
    // registers

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q       <= preview_pkg::IDLE;
            hdr_idx_q     <= '0;
            first_pixel_q <= 1'b0;
            byte_valid_o  <= 1'b0;
        end else begin
            state_q       <= state_d;
            hdr_idx_q     <= hdr_idx_d;
            first_pixel_q <= first_pixel_d;
            byte_valid_o  <= emit;
        end
    end

    always_ff @(posedge core_clk) begin
        if (emit) begin
            byte_o <= emit_byte;
        end
    end

    a_byte_needs_space: assert property (@(posedge core_clk) disable iff (sys_reset)
        byte_valid_o |-> $past(host_space_i));

endmodule

`default_nettype wire

// File: rtl/command_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module command_assembler (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  preview_pkg::pixel_t    host_byte_i,
    input  logic                   host_byte_valid_i,
    output preview_pkg::cmd_addr_t cmd_addr_o,
    output preview_pkg::cmd_data_t cmd_data_o,
    output logic                   cmd_valid_o
);

    // msb first, address lands in the top 16 bits
    logic [preview_pkg::CMD_W-1:0]     shift_q;
    logic [preview_pkg::CMD_CNT_W-1:0] byte_cnt_q;

    assign cmd_addr_o = shift_q[preview_pkg::CMD_W-1 -: 16];
    assign cmd_data_o = shift_q[31:0];

    always_ff @(posedge core_clk) begin
        if (host_byte_valid_i) begin
            shift_q <= {shift_q[preview_pkg::CMD_W-9:0], host_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q  <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (host_byte_valid_i) begin
                if (byte_cnt_q == preview_pkg::CMD_LAST) begin
                    byte_cnt_q  <= '0;
                    cmd_valid_o <= 1'b1;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module frame_config_regs (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  preview_pkg::cmd_addr_t cmd_addr_i,
    input  preview_pkg::cmd_data_t cmd_data_i,
    input  logic                   cmd_valid_i,
    output preview_pkg::dim_t      frame_width_o,
    output preview_pkg::dim_t      frame_height_o
);

    preview_pkg::dim_t data_lo;
    logic              data_ok;
    logic              wr_width;
    logic              wr_height;

    assign data_lo = cmd_data_i[15:0];

    // a zero size would stall the frame counter
    assign data_ok = cmd_valid_i && (data_lo != '0);

    assign wr_width  = data_ok && (cmd_addr_i == preview_pkg::ADDR_FRAME_WIDTH);
    assign wr_height = data_ok && (cmd_addr_i == preview_pkg::ADDR_FRAME_HEIGHT);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            frame_width_o  <= preview_pkg::DEFAULT_WIDTH;
            frame_height_o <= preview_pkg::DEFAULT_HEIGHT;
        end else begin
            if (wr_width) begin
                frame_width_o <= data_lo;
            end
            if (wr_height) begin
                frame_height_o <= data_lo;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/preview_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module preview_link_top (
    input  logic                core_clk,
    input  logic                sys_reset,
    input  preview_pkg::pixel_t pix_ch0_i,
    input  preview_pkg::pixel_t pix_ch1_i,
    input  logic                pix_sof_i,
    input  logic                pix_valid_i,
    output logic                pix_ready_o,
    input  logic                host_space_i,
    output preview_pkg::pixel_t byte_o,
    output logic                byte_valid_o,
    input  preview_pkg::pixel_t host_byte_i,
    input  logic                host_byte_valid_i
);

    ////////////////////
    // pixel buffer

    preview_pkg::pixel_t head_ch0;
    preview_pkg::pixel_t head_ch1;
    logic                head_sof;
    logic                head_valid;
    logic                pop;

    pixel_fifo u_pixel_fifo (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .push_ch0_i   (pix_ch0_i),
        .push_ch1_i   (pix_ch1_i),
        .push_sof_i   (pix_sof_i),
        .push_valid_i (pix_valid_i),
        .push_ready_o (pix_ready_o),
        .head_ch0_o   (head_ch0),
        .head_ch1_o   (head_ch1),
        .head_sof_o   (head_sof),
        .head_valid_o (head_valid),
        .pop_i        (pop)
    );

    ////////////////////
    // serializer

    logic              frame_start;
    logic              pixel_done;
    logic              last_pixel;
    preview_pkg::dim_t frame_width;
    preview_pkg::dim_t frame_height;

    frame_serializer_fsm u_serializer (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .head_ch0_i    (head_ch0),
        .head_ch1_i    (head_ch1),
        .head_sof_i    (head_sof),
        .head_valid_i  (head_valid),
        .pop_o         (pop),
        .frame_start_o (frame_start),
        .pixel_done_o  (pixel_done),
        .last_pixel_i  (last_pixel),
        .host_space_i  (host_space_i),
        .byte_o        (byte_o),
        .byte_valid_o  (byte_valid_o)
    );

    frame_position_counter u_position (
        .core_clk       (core_clk),
        .sys_reset      (sys_reset),
        .frame_width_i  (frame_width),
        .frame_height_i (frame_height),
        .frame_start_i  (frame_start),
        .pixel_done_i   (pixel_done),
        .last_pixel_o   (last_pixel)
    );

    ////////////////////
    // host commands

    preview_pkg::cmd_addr_t cmd_addr;
    preview_pkg::cmd_data_t cmd_data;
    logic                   cmd_valid;

    command_assembler u_cmd_assembler (
        .core_clk          (core_clk),
        .sys_reset         (sys_reset),
        .host_byte_i       (host_byte_i),
        .host_byte_valid_i (host_byte_valid_i),
        .cmd_addr_o        (cmd_addr),
        .cmd_data_o        (cmd_data),
        .cmd_valid_o       (cmd_valid)
    );

    frame_config_regs u_config (
        .core_clk       (core_clk),
        .sys_reset      (sys_reset),
        .cmd_addr_i     (cmd_addr),
        .cmd_data_i     (cmd_data),
        .cmd_valid_i    (cmd_valid),
        .frame_width_o  (frame_width),
        .frame_height_o (frame_height)
    );

endmodule

`default_nettype wire

// File: verif/tb_preview_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_preview_link;

    localparam int CLK_PERIOD    = 100;
    localparam int NUM_ROUNDS    = 14;
    localparam int PIX_PER_ROUND = 80;
    localparam int MAX_W         = 8;
    localparam int MAX_H         = 6;
    // every frame needs a pixel of its own to open it
    localparam int FRAMES_PER_ROUND = PIX_PER_ROUND;
    localparam int WATCHDOG_CYCLES  =
        NUM_ROUNDS * FRAMES_PER_ROUND * (MAX_W * MAX_H * 2 + 8) * 20;
    localparam int DRAIN_LIMIT = 2000;

    localparam logic [63:0] HEADER_TEXT = "BIVFRAME";
    localparam logic [15:0] WIDTH_ADDR  = 16'h0010;
    localparam logic [15:0] HEIGHT_ADDR = 16'h0011;

    logic       core_clk;
    logic       sys_reset;
    logic [7:0] pix_ch0_i;
    logic [7:0] pix_ch1_i;
    logic       pix_sof_i;
    logic       pix_valid_i;
    logic       pix_ready_o;
    logic       host_space_i;
    logic [7:0] byte_o;
    logic       byte_valid_o;
    logic [7:0] host_byte_i;
    logic       host_byte_valid_i;

    integer seed = 32'hc3b54271;

    // reference model state
    int         model_w;
    int         model_h;
    logic       in_frame;
    int         remaining;
    logic [7:0] exp_q[$];
    logic [7:0] expected_byte;
    int         space_pct;
    int         sof_odds;

    preview_link_top dut (
        .core_clk          (core_clk),
        .sys_reset         (sys_reset),
        .pix_ch0_i         (pix_ch0_i),
        .pix_ch1_i         (pix_ch1_i),
        .pix_sof_i         (pix_sof_i),
        .pix_valid_i       (pix_valid_i),
        .pix_ready_o       (pix_ready_o),
        .host_space_i      (host_space_i),
        .byte_o            (byte_o),
        .byte_valid_o      (byte_valid_o),
        .host_byte_i       (host_byte_i),
        .host_byte_valid_i (host_byte_valid_i)
    );

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    ////////////////////
    // reference model

    function automatic void accept_pixel(input logic [7:0] ch0, input logic [7:0] ch1,
                                         input logic sof);
        // sof opens a frame even mid-frame
        if (sof) begin
            for (int i = 0; i < 8; i++) begin
                exp_q.push_back(HEADER_TEXT[63 - 8 * i -: 8]);
            end
            remaining = model_w * model_h;
            in_frame  = 1'b1;
        end
        if (in_frame) begin
            exp_q.push_back(ch0);
            exp_q.push_back(ch1);
            remaining--;
            if (remaining == 0) begin
                in_frame = 1'b0;
            end
        end
    endfunction

    function automatic void apply_command(input logic [15:0] addr, input logic [31:0] data);
        if (data[15:0] != 16'h0) begin
            if (addr == WIDTH_ADDR) begin
                model_w = int'(data[15:0]);
            end else if (addr == HEIGHT_ADDR) begin
                model_h = int'(data[15:0]);
            end
        end
    endfunction

    ////////////////////
    // stimulus

    task automatic send_command(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] cmd;
        cmd = {addr, data};
        for (int i = 0; i < 6; i++) begin
            @(negedge core_clk);
            host_byte_i       = cmd[47 - 8 * i -: 8];
            host_byte_valid_i = 1'b1;
            @(negedge core_clk);
            host_byte_valid_i = 1'b0;
            repeat (rand_below(3)) @(negedge core_clk);
        end
        apply_command(addr, data);
        // registers settle two cycles after the last byte
        repeat (3) @(negedge core_clk);
    endtask

    task automatic set_size(input logic [15:0] w, input logic [15:0] h);
        send_command(WIDTH_ADDR, {16'(rand_below(65536)), w});
        send_command(HEIGHT_ADDR, {16'(rand_below(65536)), h});
    endtask

    task automatic random_command;
        int          kind;
        logic [15:0] addr;
        logic [15:0] dim;
        kind = rand_below(4);
        addr = rand_below(2) == 0 ? WIDTH_ADDR : HEIGHT_ADDR;
        dim  = 16'(rand_below(MAX_W) + 1);
        if (kind == 0) begin
            addr = WIDTH_ADDR;
        end else if (kind == 1) begin
            addr = HEIGHT_ADDR;
            dim  = 16'(rand_below(MAX_H) + 1);
        end else if (kind == 2) begin
            // unmapped address
            addr = 16'(32 + rand_below(64));
        end else begin
            dim = 16'h0;
        end
        send_command(addr, {16'(rand_below(65536)), dim});
    endtask

    task automatic drive_cycle(input logic allow_push, inout int pushed);
        logic [7:0] ch0;
        logic [7:0] ch1;
        logic       sof;
        @(negedge core_clk);
        host_space_i = (rand_below(100) < space_pct);
        pix_valid_i  = 1'b0;
        // ready only changes on the rising edge
        if (allow_push && pix_ready_o && rand_below(4) != 0) begin
            ch0         = 8'(rand_below(256));
            ch1         = 8'(rand_below(256));
            sof         = (rand_below(sof_odds) == 0);
            pix_ch0_i   = ch0;
            pix_ch1_i   = ch1;
            pix_sof_i   = sof;
            pix_valid_i = 1'b1;
            accept_pixel(ch0, ch1, sof);
            pushed++;
        end
    endtask

    task automatic drain_output;
        int waited;
        int unused;
        waited = 0;
        unused = 0;
        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, unused);
            waited++;
            assert (waited < DRAIN_LIMIT)
                else abort_run("output stalled while bytes were still expected");
        end
        // idle cycles flush dropped pixels and expose stray bytes
        repeat (20) drive_cycle(1'b0, unused);
    endtask

    task automatic run_round;
        int pushed;
        int waited;
        pushed    = 0;
        waited    = 0;
        space_pct = 20 + rand_below(81);
        sof_odds  = 6 + rand_below(30);
        while (pushed < PIX_PER_ROUND) begin
            drive_cycle(1'b1, pushed);
            waited++;
            assert (waited < PIX_PER_ROUND * 100)
                else abort_run("pixel input stalled, pix_ready_o stayed low");
        end
        drain_output();
    endtask

    ////////////////////
    // output monitor

    always @(negedge core_clk) begin
        if (!sys_reset && byte_valid_o) begin
            assert (exp_q.size() > 0)
                else abort_run($sformatf("unexpected output byte 0x%h", byte_o));
            expected_byte = exp_q.pop_front();
            assert (byte_o == expected_byte)
                else abort_run($sformatf("MISMATCH byte_o: got 0x%h expected 0x%h",
                                         byte_o, expected_byte));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the test finished");
    end

    initial begin
        core_clk          = 1'b0;
        sys_reset         = 1'b1;
        pix_ch0_i         = 8'h0;
        pix_ch1_i         = 8'h0;
        pix_sof_i         = 1'b0;
        pix_valid_i       = 1'b0;
        host_space_i      = 1'b0;
        host_byte_i       = 8'h0;
        host_byte_valid_i = 1'b0;
        model_w           = 500;
        model_h           = 480;
        in_frame          = 1'b0;
        remaining         = 0;
        space_pct         = 100;
        sof_odds          = 10;

        repeat (2) @(posedge core_clk);
        @(negedge core_clk);
        sys_reset = 1'b0;

        assert (byte_valid_o == 1'b0)
            else abort_run($sformatf("MISMATCH byte_valid_o: got 0x%h expected 0x0",
                                     byte_valid_o));
        assert (pix_ready_o == 1'b1)
            else abort_run($sformatf("MISMATCH pix_ready_o: got 0x%h expected 0x1",
                                     pix_ready_o));

        set_size(16'd6, 16'd4);
        run_round();
        set_size(16'd3, 16'd5);
        run_round();
        for (int r = 2; r < NUM_ROUNDS; r++) begin
            random_command();
            run_round();
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: preview_link_top.f
rtl/preview_pkg.sv
rtl/pixel_fifo.sv
rtl/frame_position_counter.sv
rtl/frame_serializer_fsm.sv
rtl/command_assembler.sv
rtl/frame_config_regs.sv
rtl/preview_link_top.sv
verif/tb_preview_link.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_preview_link
FILELIST  ?= preview_link_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Simulation PASSED

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
